/* common/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

	// port count and port index width
	localparam int PORT_COUNT = 4;
	localparam int PORT_WIDTH = 2;

	// word fields
	localparam int CTRL_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	// destination sits in the lowest control bits
	localparam int DEST_LSB = 0;

	// ingress queue sizing
	localparam int QUEUE_DEPTH = 8;
	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int COUNT_WIDTH = PTR_WIDTH + 1;
	localparam logic [COUNT_WIDTH-1:0] QUEUE_FULL_COUNT = COUNT_WIDTH'(QUEUE_DEPTH);

	// one word as carried through the crossbar
	typedef struct packed {
		logic [CTRL_WIDTH-1:0] ctrl;
		logic [DATA_WIDTH-1:0] data;
	} port_word_t;

	// valid bit is a one-cycle write strobe or pulse
	typedef struct packed {
		logic       valid;
		port_word_t word;
	} port_beat_t;

	// src names the input that won one egress port
	typedef struct packed {
		logic                  valid;
		logic [PORT_WIDTH-1:0] src;
	} grant_t;

endpackage

`default_nettype wire

/* source/ingress_queue.sv */
`default_nettype none

module ingress_queue (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 write,
	input  wire xbar_pkg::port_word_t word_in,
	input  wire logic                 pop,
	output xbar_pkg::port_word_t      head,
	output logic                      empty
);

	// payload storage
	xbar_pkg::port_word_t mem [xbar_pkg::QUEUE_DEPTH];

	logic [xbar_pkg::PTR_WIDTH-1:0]   rd_ptr;
	logic [xbar_pkg::PTR_WIDTH-1:0]   wr_ptr;
	logic [xbar_pkg::COUNT_WIDTH-1:0] count;

	logic full;
	logic do_write;
	logic do_pop;

	assign full  = (count == xbar_pkg::QUEUE_FULL_COUNT);
	assign empty = (count == '0);

	// a write into a full queue is lost
	assign do_write = write & ~full;
	assign do_pop   = pop & ~empty;

	// first word falls through
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= word_in;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// pop and write together leave the occupancy alone
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
		end else begin
			case ({do_write, do_pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/port_allocator.sv */
`default_nettype none

module port_allocator (
	input  wire xbar_pkg::port_word_t [xbar_pkg::PORT_COUNT-1:0] head,
	input  wire logic [xbar_pkg::PORT_COUNT-1:0]                 empty,
	output logic [xbar_pkg::PORT_COUNT-1:0]                      pop,
	output xbar_pkg::grant_t [xbar_pkg::PORT_COUNT-1:0]          grant
);

	// destination of each queue head
	logic [xbar_pkg::PORT_WIDTH-1:0] dest [xbar_pkg::PORT_COUNT];

	// req[p][i] means input i wants egress p
	logic [xbar_pkg::PORT_COUNT-1:0][xbar_pkg::PORT_COUNT-1:0] req;

	always_comb begin
		for (int i = 0; i < xbar_pkg::PORT_COUNT; i++) begin
			dest[i] = head[i].ctrl[xbar_pkg::DEST_LSB +: xbar_pkg::PORT_WIDTH];
		end
	end

	// empty queues request nothing
	always_comb begin
		req = '0;
		for (int i = 0; i < xbar_pkg::PORT_COUNT; i++) begin
			if (!empty[i]) begin
				req[dest[i]][i] = 1'b1;
			end
		end
	end

	// lowest input number wins each egress
	always_comb begin
		grant = '0;
		for (int p = 0; p < xbar_pkg::PORT_COUNT; p++) begin
			for (int i = 0; i < xbar_pkg::PORT_COUNT; i++) begin
				if (req[p][i] && !grant[p].valid) begin
					grant[p].valid = 1'b1;
					grant[p].src   = i[xbar_pkg::PORT_WIDTH-1:0];
				end
			end
		end
	end

	// a head only leaves its queue when it won
	// each input asks for a single egress, so at most one grant per input
	always_comb begin
		pop = '0;
		for (int p = 0; p < xbar_pkg::PORT_COUNT; p++) begin
			if (grant[p].valid) begin
				pop[grant[p].src] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/output_switch.sv */
`default_nettype none

module output_switch (
	input  wire logic                                            clk,
	input  wire logic                                            rst,
	input  wire xbar_pkg::grant_t [xbar_pkg::PORT_COUNT-1:0]     grant,
	input  wire xbar_pkg::port_word_t [xbar_pkg::PORT_COUNT-1:0] head,
	output xbar_pkg::port_beat_t [xbar_pkg::PORT_COUNT-1:0]      egress
);

	// word picked for each egress this cycle
	xbar_pkg::port_word_t [xbar_pkg::PORT_COUNT-1:0] selected;

	always_comb begin
		for (int p = 0; p < xbar_pkg::PORT_COUNT; p++) begin
			selected[p] = head[grant[p].src];
		end
	end

	// write pulse lasts one cycle and the word holds until the next grant
	for (genvar p = 0; p < xbar_pkg::PORT_COUNT; p++) begin : g_egress
		always_ff @(posedge clk or negedge rst) begin
			if (!rst) begin
				egress[p].valid <= 1'b0;
			end else begin
				egress[p].valid <= grant[p].valid;
			end
		end

		always_ff @(posedge clk or negedge rst) begin
			if (!rst) begin
				egress[p].word <= '0;
			end else if (grant[p].valid) begin
				egress[p].word <= selected[p];
			end
		end
	end

endmodule

`default_nettype wire

/* source/xbar_top.sv */
`default_nettype none

module xbar_top (
	input  wire logic                                            clk,
	input  wire logic                                            rst,
	input  wire xbar_pkg::port_beat_t [xbar_pkg::PORT_COUNT-1:0] ingress,
	output wire xbar_pkg::port_beat_t [xbar_pkg::PORT_COUNT-1:0] egress
);

	// queue heads and status
	wire xbar_pkg::port_word_t [xbar_pkg::PORT_COUNT-1:0] head;
	wire logic [xbar_pkg::PORT_COUNT-1:0]                 empty;

	// allocator results
	wire logic [xbar_pkg::PORT_COUNT-1:0]             pop;
	wire xbar_pkg::grant_t [xbar_pkg::PORT_COUNT-1:0] grant;

	// one queue per input port
	for (genvar i = 0; i < xbar_pkg::PORT_COUNT; i++) begin : g_queue
		ingress_queue u_ingress_queue (
			.clk     (clk),
			.rst     (rst),
			.write   (ingress[i].valid),
			.word_in (ingress[i].word),
			.pop     (pop[i]),
			.head    (head[i]),
			.empty   (empty[i])
		);
	end

	port_allocator u_port_allocator (
		.head  (head),
		.empty (empty),
		.pop   (pop),
		.grant (grant)
	);

	// egress registered one edge after the grant
	output_switch u_output_switch (
		.clk    (clk),
		.rst    (rst),
		.grant  (grant),
		.head   (head),
		.egress (egress)
	);

endmodule

`default_nettype wire

/* verification/xbar_tb.sv */
`default_nettype none

module xbar_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst;
	xbar_pkg::port_beat_t [xbar_pkg::PORT_COUNT-1:0] ingress;
	xbar_pkg::port_beat_t [xbar_pkg::PORT_COUNT-1:0] egress;

	// counts clock edges since reset release
	int cyc = 0;
	int errors = 0;
	int checked = 0;

	// stimulus lines from the data file
	int                   st_cyc [$];
	int                   st_port [$];
	xbar_pkg::port_word_t st_word [$];
	int                   st_dest [$];
	int                   st_kept [$];
	int                   st_lat [$];

	// expected words indexed by egress * PORT_COUNT + source
	xbar_pkg::port_word_t exp_word [xbar_pkg::PORT_COUNT*xbar_pkg::PORT_COUNT][$];
	int                   exp_cyc [xbar_pkg::PORT_COUNT*xbar_pkg::PORT_COUNT][$];
	int                   exp_lat [xbar_pkg::PORT_COUNT*xbar_pkg::PORT_COUNT][$];

	xbar_top u_xbar_top (
		.clk     (clk),
		.rst     (rst),
		.ingress (ingress),
		.egress  (egress)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			cyc <= cyc + 1;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("Fail %s: got %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		int c;
		int port;
		int dest;
		int kept;
		int lat;
		int tag_dest;
		int tag_src;
		logic [31:0] ctrl;
		logic [31:0] data;
		string line;
		xbar_pkg::port_word_t w;
		fd = $fopen("verification/xbar_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/xbar_testdata.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %h %h %d %d %d",
					c, port, ctrl, data, dest, kept, lat);
				if (n == 7) begin
					w.ctrl = ctrl[xbar_pkg::CTRL_WIDTH-1:0];
					w.data = data;
					tag_dest = int'(w.ctrl[xbar_pkg::DEST_LSB +: xbar_pkg::PORT_WIDTH]);
					tag_src  = int'(w.ctrl[xbar_pkg::PORT_WIDTH +: xbar_pkg::PORT_WIDTH]);
					// destination rule and source tag must agree with the columns
					if (port < 0 || port >= xbar_pkg::PORT_COUNT) begin
						$display("test data line for cycle %0d names a bad port", c);
						errors++;
					end else if (dest != tag_dest) begin
						$display("test data line for cycle %0d has a wrong egress port", c);
						errors++;
					end else if (port != tag_src) begin
						$display("test data line for cycle %0d has a wrong source tag", c);
						errors++;
					end else begin
						st_cyc.push_back(c);
						st_port.push_back(port);
						st_word.push_back(w);
						st_dest.push_back(dest);
						st_kept.push_back(kept);
						st_lat.push_back(lat);
					end
				end else if (n > 0) begin
					$display("malformed line in test data: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_word(input int idx);
		int key;
		key = st_dest[idx] * xbar_pkg::PORT_COUNT + st_port[idx];
		ingress[st_port[idx]].valid = 1'b1;
		ingress[st_port[idx]].word  = st_word[idx];
		if (st_kept[idx] != 0) begin
			exp_word[key].push_back(st_word[idx]);
			exp_cyc[key].push_back(cyc);
			exp_lat[key].push_back(st_lat[idx]);
		end
	endtask

	task automatic run_stimulus();
		int idx;
		int idle;
		idx = 0;
		idle = 0;
		while (idx < st_cyc.size() && idle < 1000) begin
			@(posedge clk);
			#2;
			ingress = '0;
			idle++;
			while (idx < st_cyc.size() && st_cyc[idx] <= cyc) begin
				if (st_cyc[idx] < cyc) begin
					$display("test data line for cycle %0d is out of order", st_cyc[idx]);
					errors++;
				end else begin
					drive_word(idx);
					idle = 0;
				end
				idx++;
			end
		end
		if (idx < st_cyc.size()) begin
			$display("stimulus stalled before cycle %0d", st_cyc[idx]);
			errors++;
		end
		@(posedge clk);
		#2;
		ingress = '0;
	endtask

	task automatic check_delivery(input int p, input xbar_pkg::port_word_t w);
		int src;
		int key;
		int sent;
		int lat;
		xbar_pkg::port_word_t want;
		src = int'(w.ctrl[xbar_pkg::PORT_WIDTH +: xbar_pkg::PORT_WIDTH]);
		key = p * xbar_pkg::PORT_COUNT + src;
		if (exp_word[key].size() == 0) begin
			$display("egress %0d delivered word %h from input %0d that was not expected",
				p, w, src);
			errors++;
		end else begin
			want = exp_word[key].pop_front();
			sent = exp_cyc[key].pop_front();
			lat  = exp_lat[key].pop_front();
			check_value($sformatf("egress[%0d].word", p), 64'(w), 64'(want));
			// zero latency in the data file means not checked
			if (lat != 0) begin
				check_value($sformatf("egress[%0d] latency", p), 64'(cyc - sent), 64'(lat));
			end
			checked++;
		end
	endtask

	// egress only changes at the rising edge
	always @(negedge clk) begin
		if (rst) begin
			for (int p = 0; p < xbar_pkg::PORT_COUNT; p++) begin
				if (egress[p].valid) begin
					check_delivery(p, egress[p].word);
				end
			end
		end
	end

	function automatic int pending_words();
		int total;
		total = 0;
		for (int key = 0; key < $size(exp_word); key++) begin
			total += exp_word[key].size();
		end
		return total;
	endfunction

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending_words() != 0 && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		for (int key = 0; key < $size(exp_word); key++) begin
			if (exp_word[key].size() != 0) begin
				$display("timeout: egress %0d still waits for %0d words from input %0d",
					key / xbar_pkg::PORT_COUNT, exp_word[key].size(),
					key % xbar_pkg::PORT_COUNT);
				errors++;
			end
		end
		// a word that should have been dropped would still come out here
		repeat (20) begin
			@(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		ingress = '0;
		load_stimulus();
		repeat (8) begin
			@(posedge clk);
		end
		#2;
		rst = 1'b1;
		run_stimulus();
		wait_drain();
		$display("checked %0d words, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/xbar_testdata.txt */
# cycle port ctrl(hex) data(hex) egress kept latency
# ctrl[1:0] is the egress port, ctrl[3:2] the source port, latency 0 is not checked
# one word per input, distinct egress ports
12 0 31 10000001 1 1 2
12 1 47 10000002 3 1 2
12 2 58 10000003 0 1 2
12 3 6e 10000004 2 1 2
15 0 80 10000005 0 1 2
15 1 96 10000006 2 1 2
15 2 ab 10000007 3 1 2
15 3 cd 10000008 1 1 2
# four inputs to egress 2 in the same cycle
20 0 72 20000001 2 1 2
20 1 86 20000002 2 1 3
20 2 9a 20000003 2 1 4
20 3 ae 20000004 2 1 5
# burst from input 3 to mixed egress ports
30 3 bc 30000001 0 1 2
31 3 cd 30000002 1 1 2
32 3 de 30000003 2 1 2
33 3 ef 30000004 3 1 2
34 3 1c 30000005 0 1 2
35 3 2e 30000006 2 1 2
36 3 3d 30000007 1 1 2
37 3 4f 30000008 3 1 2
38 3 5f 30000009 3 1 2
39 3 6c 3000000a 0 1 2
# input 0 holds egress 1 while input 1 fills its queue, ninth word is dropped
50 0 01 40000001 1 1 2
51 0 11 40000002 1 1 2
51 1 05 41000001 1 1 0
52 0 21 40000003 1 1 2
52 1 15 41000002 1 1 0
53 0 31 40000004 1 1 2
53 1 25 41000003 1 1 0
54 0 41 40000005 1 1 2
54 1 35 41000004 1 1 0
55 0 51 40000006 1 1 2
55 1 45 41000005 1 1 0
56 0 61 40000007 1 1 2
56 1 55 41000006 1 1 0
57 0 71 40000008 1 1 2
57 1 65 41000007 1 1 0
58 0 81 40000009 1 1 2
58 1 75 41000008 1 1 0
59 0 91 4000000a 1 1 2
59 1 85 41000009 1 0 0
60 0 a1 4000000b 1 1 2
61 0 b1 4000000c 1 1 2

/* all.f */
common/xbar_pkg.sv
source/ingress_queue.sv
source/port_allocator.sv
source/output_switch.sv
source/xbar_top.sv
verification/xbar_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the crossbar testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module xbar_tb -f all.f --Mdir obj_dir -o xbar_sim \
	&& ./obj_dir/xbar_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -qx "Test OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
